// File: all.f
hw/rvtrace_pkg.sv
hw/rv32_field_decode.sv
hw/rvc_field_decode.sv
hw/retire_counters.sv
hw/rvtrace_wb_top.sv
tb/rvtrace_properties.sv
tb/rvtrace_tb.sv

// File: tb/rvtrace_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the Wishbone instruction classifier.
// Writes random full-length and compressed words, reads back
// the result and the retirement counters, and compares them
// with a reference model kept in this file.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module rvtrace_tb import rvtrace_pkg::*; ();

    localparam int NUM_TRANS      = 400;
    localparam int TIMEOUT_CYCLES = NUM_TRANS * 3 * 3 + 200;
    localparam logic [4:0] OPCODES [11] = '{OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR,
        OPC_BRANCH, OPC_LOAD, OPC_STORE, OPC_OPIMM, OPC_OP, OPC_FENCE, OPC_SYSTEM};

    logic     s_clk;
    logic     reset;
    logic     wb_cyc;
    logic     wb_stb;
    logic     wb_we;
    wb_adr_t  wb_adr;
    xlen_t    wb_dat_w;
    logic     wb_ack;
    xlen_t    wb_dat_r;
    integer   seed;
    int       cycle_cnt;
    ret_cnt_t model_cnt [NUM_ITYPES];
    ret_cnt_t model_total;

    rvtrace_wb_top rvtrace_wb_top_i (
        .s_clk_i(s_clk), .reset_i(reset),
        .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_we_i(wb_we),
        .wb_adr_i(wb_adr), .wb_dat_i(wb_dat_w),
        .wb_ack_o(wb_ack), .wb_dat_o(wb_dat_r)
    );

    always #4 s_clk = ~s_clk;

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    always @(posedge s_clk) begin
        cycle_cnt++;
        if (cycle_cnt > TIMEOUT_CYCLES) begin
            stop_with_failure($sformatf("timeout, run exceeded %0d cycles", TIMEOUT_CYCLES));
        end
    end

    task automatic check_result(input string name, input xlen_t exp, input xlen_t act);
        if (act !== exp) begin
            stop_with_failure($sformatf("Fail %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_count(input string name, input ret_cnt_t exp, input ret_cnt_t act);
        if (act !== exp) begin
            stop_with_failure($sformatf("Fail %s expected %0d actual %0d", name, exp, act));
        end
    endtask

    task automatic check_ack(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            stop_with_failure($sformatf("Fail %s expected %b actual %b", name, exp, act));
        end
    endtask

    // unused registers read as zero, and an illegal word clears every field.
    function automatic xlen_t pack_result(input logic ok, input logic comp, input itype_e it,
                                          input logic u1, input logic u2, input logic ud,
                                          input regidx_t r1, input regidx_t r2,
                                          input regidx_t rd);
        if (!ok) begin
            return {9'd0, 1'b0, comp, 21'd0};
        end
        return {9'd0, 1'b1, comp, it, ud, u2, u1, ud ? rd : 5'd0, u2 ? r2 : 5'd0,
                u1 ? r1 : 5'd0};
    endfunction

    function automatic xlen_t model_rv32(input xlen_t w);
        logic [2:0] f3;
        logic [6:0] f7;
        regidx_t    r1;
        regidx_t    r2;
        regidx_t    rd;
        logic       ok;
        f3 = w[14:12];
        f7 = w[31:25];
        r1 = w[19:15];
        r2 = w[24:20];
        rd = w[11:7];
        case (w[6:2])
            OPC_LUI, OPC_AUIPC: return pack_result(1'b1, 1'b0, BASE, 0, 0, 1, r1, r2, rd);
            OPC_JAL:    return pack_result(1'b1, 1'b0, JAL, 0, 0, 1, r1, r2, rd);
            OPC_JALR:   return pack_result(f3 == 0, 1'b0, JALR, 1, 0, 1, r1, r2, rd);
            OPC_BRANCH: return pack_result(f3 != 2 && f3 != 3, 1'b0, BRANCH, 1, 1, 0, r1, r2, rd);
            OPC_LOAD:   return pack_result(f3 != 3 && f3 < 6, 1'b0, LOAD, 1, 0, 1, r1, r2, rd);
            OPC_STORE:  return pack_result(f3 < 3, 1'b0, STORE, 1, 1, 0, r1, r2, rd);
            OPC_OPIMM: begin
                ok = !(f3 == 1 && f7 != 0) && !(f3 == 5 && f7 != 0 && f7 != 32);
                return pack_result(ok, 1'b0, BASE, 1, 0, 1, r1, r2, rd);
            end
            OPC_OP: begin
                if (f7 == 1) begin
                    return pack_result(1'b1, 1'b0, MEXT, 1, 1, 1, r1, r2, rd);
                end
                ok = (f7 == 0) || (f7 == 32 && (f3 == 0 || f3 == 5));
                return pack_result(ok, 1'b0, BASE, 1, 1, 1, r1, r2, rd);
            end
            OPC_FENCE: return pack_result(f3 < 2, 1'b0, CSR, 0, 0, 0, r1, r2, rd);
            OPC_SYSTEM: begin
                if (f3 == 0) begin
                    ok = r1 == 0 && rd == 0 && (w[31:20] == 0 || w[31:20] == 1
                         || w[31:20] == 12'h302);
                    return pack_result(ok, 1'b0, CSR, 0, 0, 0, r1, r2, rd);
                end
                return pack_result(f3 != 4, 1'b0, CSR, f3 < 4, 0, 1, r1, r2, rd);
            end
            default: return pack_result(1'b0, 1'b0, BASE, 0, 0, 0, r1, r2, rd);
        endcase
    endfunction

    function automatic xlen_t model_rvc(input xlen_t w);
        regidx_t rf;
        regidx_t r2f;
        regidx_t rhp;
        regidx_t rlp;
        rf  = w[11:7];
        r2f = w[6:2];
        rhp = 5'd8 + w[9:7];
        rlp = 5'd8 + w[4:2];
        case ({w[1:0], w[15:13]})
            5'b00_000: return pack_result(|w[12:5], 1'b1, BASE, 1, 0, 1, 2, 0, rlp);
            5'b00_010: return pack_result(1'b1, 1'b1, LOAD, 1, 0, 1, rhp, 0, rlp);
            5'b00_110: return pack_result(1'b1, 1'b1, STORE, 1, 1, 0, rhp, rlp, 0);
            5'b01_000: return pack_result(1'b1, 1'b1, BASE, 1, 0, 1, rf, 0, rf);
            5'b01_001: return pack_result(1'b1, 1'b1, JAL, 0, 0, 1, 0, 0, 1);
            5'b01_010: return pack_result(1'b1, 1'b1, BASE, 0, 0, 1, 0, 0, rf);
            5'b01_011: return pack_result(w[12] || r2f != 0, 1'b1, BASE, rf == 2, 0, 1, 2, 0, rf);
            5'b01_100: begin
                if (w[11:10] == 2'b11) begin
                    return pack_result(!w[12], 1'b1, BASE, 1, 1, 1, rhp, rlp, rhp);
                end
                return pack_result(w[11] || r2f != 0, 1'b1, BASE, 1, 0, 1, rhp, 0, rhp);
            end
            5'b01_101: return pack_result(1'b1, 1'b1, JAL, 0, 0, 1, 0, 0, 0);
            5'b01_110, 5'b01_111: return pack_result(1'b1, 1'b1, BRANCH, 1, 0, 0, rhp, 0, 0);
            5'b10_000: begin
                return pack_result(!w[12] && rf != 0 && r2f != 0, 1'b1, BASE, 1, 0, 1,
                                   rf, 0, rf);
            end
            5'b10_010: return pack_result(rf != 0, 1'b1, LOAD, 1, 0, 1, 2, 0, rf);
            5'b10_100: begin
                if (w[12] && w[11:2] == 0) begin
                    return pack_result(1'b1, 1'b1, CSR, 0, 0, 0, 0, 0, 0);
                end else if (r2f != 0) begin
                    return pack_result(1'b1, 1'b1, BASE, w[12], 1, 1, rf, r2f, rf);
                end
                return pack_result(rf != 0, 1'b1, JALR, 1, 0, 1, rf, 0, {4'd0, w[12]});
            end
            5'b10_110: return pack_result(1'b1, 1'b1, STORE, 1, 1, 0, 2, r2f, 0);
            default:   return pack_result(1'b0, 1'b1, BASE, 0, 0, 0, 0, 0, 0);
        endcase
    endfunction

    task automatic wb_xfer(input logic we, input wb_adr_t adr, input xlen_t wdat,
                           output xlen_t rdat);
        int waits;
        check_ack("ack idle before request", 1'b0, wb_ack);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdat;
        waits    = 0;
        do begin
            @(posedge s_clk);
            #1;
            waits++;
        end while (!wb_ack);
        if (waits != 1) begin
            stop_with_failure($sformatf("ack came %0d cycles after the request, not 1", waits));
        end
        rdat = wb_dat_r;
        // the master holds the request through the ack cycle.
        @(posedge s_clk);
        #1;
        check_ack("ack drops after one cycle", 1'b0, wb_ack);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic gen_word(output xlen_t w);
        logic [4:0] opc;
        int         pick;
        w = $random(seed);
        if ($random(seed) & 1) begin
            opc    = OPCODES[{$random(seed)} % 11];
            w[6:0] = {opc, 2'b11};
            // steer funct7 towards the encodings that exist.
            if ((opc == OPC_OP || opc == OPC_OPIMM) && ($random(seed) & 1)) begin
                pick      = {$random(seed)} % 3;
                w[31:25]  = (pick == 0) ? 7'd0 : (pick == 1) ? 7'd1 : 7'd32;
            end
        end else if (w[1:0] == 2'b11) begin
            w[1:0] = 2'({$random(seed)} % 3);
        end
    endtask

    task automatic check_all_counters(input string tag);
        xlen_t rdat;
        for (int t = 0; t < NUM_ITYPES; t++) begin
            wb_xfer(1'b0, wb_adr_t'(ADR_CNT_BASE + t), '0, rdat);
            check_count($sformatf("%s type %0d", tag, t), model_cnt[t], rdat[15:0]);
        end
        wb_xfer(1'b0, ADR_TOTAL, '0, rdat);
        check_count({tag, " total"}, model_total, rdat[15:0]);
    endtask

    task automatic clear_model_counts();
        model_total = '0;
        for (int t = 0; t < NUM_ITYPES; t++) begin
            model_cnt[t] = '0;
        end
    endtask

    initial begin
        xlen_t w;
        xlen_t rdat;
        xlen_t expected;
        seed      = 73149;
        cycle_cnt = 0;
        s_clk     = 1'b0;
        reset     = 1'b1;
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_we     = 1'b0;
        wb_adr    = '0;
        wb_dat_w  = '0;
        clear_model_counts();
        repeat (5) @(posedge s_clk);
        #1;
        reset = 1'b0;

        for (int a = 0; a < 16; a++) begin
            wb_xfer(1'b0, wb_adr_t'(a), '0, rdat);
            check_result($sformatf("reset read adr %0d", a), '0, rdat);
        end

        for (int n = 0; n < NUM_TRANS; n++) begin
            gen_word(w);
            wb_xfer(1'b1, ADR_INSTR, w, rdat);
            wb_xfer(1'b0, ADR_INSTR, '0, rdat);
            expected = (w[1:0] == 2'b11) ? model_rv32(w) : model_rvc(w);
            check_result($sformatf("instr %0d word %h", n, w), expected, rdat);
            if (expected[22]) begin
                model_cnt[expected[20:18]]++;
                model_total++;
            end
            if ((n + 1) % 50 == 0) begin
                check_all_counters($sformatf("after %0d", n + 1));
            end
            if (n + 1 == NUM_TRANS / 2) begin
                wb_xfer(1'b1, ADR_CLEAR, $random(seed), rdat);
                clear_model_counts();
                check_all_counters("after clear");
            end
        end

        // writes to the read-only counters must leave them unchanged.
        wb_xfer(1'b1, ADR_TOTAL, 32'h1234_5678, rdat);
        wb_xfer(1'b1, ADR_CNT_BASE, 32'h1234_5678, rdat);
        check_all_counters("read-only write");

        for (int a = 1; a < ADR_CNT_BASE; a++) begin
            if (a != ADR_TOTAL) begin
                wb_xfer(1'b0, wb_adr_t'(a), '0, rdat);
                check_result($sformatf("unmapped read adr %0d", a), '0, rdat);
            end
        end
        $display(">>> PASS");
        $finish;
    end

endmodule

// File: tb/rvtrace_properties.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Wishbone classic protocol assertions for the classifier top.
// Bound into rvtrace_wb_top, they watch the ack handshake.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module rvtrace_properties (
    input logic s_clk_i,
    input logic reset_i,
    input logic cyc_i,
    input logic stb_i,
    input logic ack_i
);

    // ack belongs to a request that the master still holds.
    ack_needs_request: assert property (@(posedge s_clk_i) disable iff (reset_i)
        ack_i |-> (cyc_i && stb_i))
        else $error("ack high while cyc or stb is low");

    ack_single_cycle: assert property (@(posedge s_clk_i) disable iff (reset_i)
        ack_i |=> !ack_i)
        else $error("ack high for two consecutive cycles");

    ack_low_after_reset: assert property (@(posedge s_clk_i)
        reset_i |=> !ack_i)
        else $error("ack high in the cycle after reset");

endmodule

bind rvtrace_wb_top rvtrace_properties rvtrace_properties_i (
    .s_clk_i(s_clk_i),
    .reset_i(reset_i),
    .cyc_i(wb_cyc_i),
    .stb_i(wb_stb_i),
    .ack_i(wb_ack_o)
);

// File: hw/rvtrace_wb_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Wishbone classic slave around the instruction classifier.
// Writing ADR_INSTR decodes the word and stores the result,
// ADR_CLEAR resets the counters, other addresses read counters.
// Every request is acknowledged one cycle after it starts.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module rvtrace_wb_top import rvtrace_pkg::*; (
    input  logic    s_clk_i,
    input  logic    reset_i,
    input  logic    wb_cyc_i,
    input  logic    wb_stb_i,
    input  logic    wb_we_i,
    input  wb_adr_t wb_adr_i,
    input  xlen_t   wb_dat_i,
    output logic    wb_ack_o,
    output xlen_t   wb_dat_o
);

    logic     ack_q;
    logic     wr_en;
    logic     instr_wr;
    logic     is_rvc;
    xlen_t    result_d;
    xlen_t    result_q;
    ret_cnt_t count;

    itype_e   i_itype, c_itype, sel_itype;
    regidx_t  i_rs1, i_rs2, i_rd, c_rs1, c_rs2, c_rd;
    logic     i_rs1_used, i_rs2_used, i_rd_used, i_legal;
    logic     c_rs1_used, c_rs2_used, c_rd_used, c_legal;
    logic     sel_legal;

    // the write lands on the same edge that raises ack.
    assign wr_en    = wb_cyc_i && wb_stb_i && wb_we_i && !ack_q;
    assign instr_wr = wr_en && (wb_adr_i == ADR_INSTR);
    assign is_rvc   = (wb_dat_i[1:0] != 2'b11);

    always_ff @(posedge s_clk_i) begin
        if (reset_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= wb_cyc_i && wb_stb_i && !ack_q;
        end
    end

    rv32_field_decode rv32_field_decode_i (
        .instr_i(wb_dat_i), .itype_o(i_itype),
        .rs1_o(i_rs1), .rs2_o(i_rs2), .rd_o(i_rd),
        .rs1_used_o(i_rs1_used), .rs2_used_o(i_rs2_used), .rd_used_o(i_rd_used),
        .legal_o(i_legal)
    );

    rvc_field_decode rvc_field_decode_i (
        .instr_i(wb_dat_i), .itype_o(c_itype),
        .rs1_o(c_rs1), .rs2_o(c_rs2), .rd_o(c_rd),
        .rs1_used_o(c_rs1_used), .rs2_used_o(c_rs2_used), .rd_used_o(c_rd_used),
        .legal_o(c_legal)
    );

    assign sel_itype = is_rvc ? c_itype : i_itype;
    assign sel_legal = is_rvc ? c_legal : i_legal;

    always_comb begin
        result_d = '0;
        result_d[RES_RS1_LSB +: 5]   = is_rvc ? c_rs1 : i_rs1;
        result_d[RES_RS2_LSB +: 5]   = is_rvc ? c_rs2 : i_rs2;
        result_d[RES_RD_LSB +: 5]    = is_rvc ? c_rd : i_rd;
        result_d[RES_RS1_USED]       = is_rvc ? c_rs1_used : i_rs1_used;
        result_d[RES_RS2_USED]       = is_rvc ? c_rs2_used : i_rs2_used;
        result_d[RES_RD_USED]        = is_rvc ? c_rd_used : i_rd_used;
        result_d[RES_ITYPE_LSB +: 3] = sel_itype;
        result_d[RES_COMPRESSED]     = is_rvc;
        result_d[RES_LEGAL]          = sel_legal;
    end

    always_ff @(posedge s_clk_i) begin
        if (reset_i) begin
            result_q <= '0;
        end else if (instr_wr) begin
            result_q <= result_d;
        end
    end

    // illegal words still update the result but never retire.
    retire_counters retire_counters_i (
        .s_clk_i(s_clk_i), .reset_i(reset_i),
        .retire_i(instr_wr && sel_legal), .retire_type_i(sel_itype),
        .clear_i(wr_en && (wb_adr_i == ADR_CLEAR)),
        .sel_i(wb_adr_i), .count_o(count)
    );

    assign wb_ack_o = ack_q;
    assign wb_dat_o = (wb_adr_i == ADR_INSTR) ? result_q : {16'd0, count};

endmodule

// File: hw/retire_counters.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Saturating retirement counters, one per instruction type and
// one total. A retire strobe counts on the next edge, clear
// wins over retire, and sel_i picks the counter to read.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module retire_counters import rvtrace_pkg::*; (
    input  logic     s_clk_i,
    input  logic     reset_i,
    input  logic     retire_i,
    input  itype_e   retire_type_i,
    input  logic     clear_i,
    input  wb_adr_t  sel_i,
    output ret_cnt_t count_o
);

    ret_cnt_t type_cnt_q [NUM_ITYPES];
    ret_cnt_t total_cnt_q;
    logic [2:0] cnt_idx;

    function automatic ret_cnt_t sat_inc(input ret_cnt_t value);
        return (value == '1) ? value : value + 1'b1;
    endfunction

    always_ff @(posedge s_clk_i) begin
        if (reset_i || clear_i) begin
            total_cnt_q <= '0;
            for (int i = 0; i < NUM_ITYPES; i++) begin
                type_cnt_q[i] <= '0;
            end
        end else if (retire_i) begin
            total_cnt_q               <= sat_inc(total_cnt_q);
            type_cnt_q[retire_type_i] <= sat_inc(type_cnt_q[retire_type_i]);
        end
    end

    assign cnt_idx = 3'(sel_i - ADR_CNT_BASE);

    always_comb begin
        count_o = '0;
        if (sel_i == ADR_TOTAL) begin
            count_o = total_cnt_q;
        end else if (sel_i >= ADR_CNT_BASE && sel_i < ADR_CNT_BASE + NUM_ITYPES) begin
            count_o = type_cnt_q[cnt_idx];
        end
    end

endmodule

// File: hw/rvc_field_decode.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Combinational decoder for compressed (RVC) instructions.
// Produces the same fields as the full-length decoder, with
// 3-bit register fields mapped to x8..x15 and sp/ra implied.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module rvc_field_decode import rvtrace_pkg::*; (
    input  xlen_t   instr_i,
    output itype_e  itype_o,
    output regidx_t rs1_o,
    output regidx_t rs2_o,
    output regidx_t rd_o,
    output logic    rs1_used_o,
    output logic    rs2_used_o,
    output logic    rd_used_o,
    output logic    legal_o
);

    logic [2:0] funct3;
    regidx_t    r_full;
    regidx_t    r2_full;
    regidx_t    r_hi_p;
    regidx_t    r_lo_p;
    logic       imm6_nz;
    regidx_t    rs1_d;
    regidx_t    rs2_d;
    regidx_t    rd_d;

    assign funct3  = instr_i[15:13];
    assign r_full  = instr_i[11:7];
    assign r2_full = instr_i[6:2];
    assign r_hi_p  = {2'b01, instr_i[9:7]};
    assign r_lo_p  = {2'b01, instr_i[4:2]};
    assign imm6_nz = |{instr_i[12], instr_i[6:2]};

    always_comb begin
        itype_o    = BASE;
        rs1_d      = 5'd0;
        rs2_d      = 5'd0;
        rd_d       = 5'd0;
        rs1_used_o = 1'b0;
        rs2_used_o = 1'b0;
        rd_used_o  = 1'b0;
        legal_o    = 1'b0;
        case ({instr_i[1:0], funct3})
            5'b00_000: begin
                // addi4spn, the zero immediate is reserved.
                {rs1_d, rd_d} = {5'd2, r_lo_p};
                {rs1_used_o, rd_used_o, legal_o} = {2'b11, |instr_i[12:5]};
            end
            5'b00_010: begin
                itype_o = LOAD;
                {rs1_d, rd_d} = {r_hi_p, r_lo_p};
                {rs1_used_o, rd_used_o, legal_o} = 3'b111;
            end
            5'b00_110: begin
                itype_o = STORE;
                {rs1_d, rs2_d} = {r_hi_p, r_lo_p};
                {rs1_used_o, rs2_used_o, legal_o} = 3'b111;
            end
            5'b01_000: begin
                {rs1_d, rd_d} = {r_full, r_full};
                {rs1_used_o, rd_used_o, legal_o} = 3'b111;
            end
            5'b01_001: begin
                itype_o = JAL;
                rd_d = 5'd1;
                {rd_used_o, legal_o} = 2'b11;
            end
            5'b01_010: begin
                rd_d = r_full;
                {rd_used_o, legal_o} = 2'b11;
            end
            5'b01_011: begin
                // lui for any rd but sp, addi16sp when rd is sp.
                rd_d = r_full;
                rs1_d = 5'd2;
                rs1_used_o = (r_full == 5'd2);
                {rd_used_o, legal_o} = {1'b1, imm6_nz};
            end
            5'b01_100: begin
                {rs1_d, rd_d, rs2_d} = {r_hi_p, r_hi_p, r_lo_p};
                {rs1_used_o, rd_used_o} = 2'b11;
                case (instr_i[11:10])
                    2'b10:   legal_o = 1'b1;
                    2'b11: begin
                        rs2_used_o = 1'b1;
                        legal_o    = !instr_i[12];
                    end
                    default: legal_o = (r2_full != 5'd0);
                endcase
            end
            5'b01_101: begin
                itype_o = JAL;
                {rd_used_o, legal_o} = 2'b11;
            end
            5'b01_110, 5'b01_111: begin
                itype_o = BRANCH;
                rs1_d = r_hi_p;
                {rs1_used_o, legal_o} = 2'b11;
            end
            5'b10_000: begin
                {rs1_d, rd_d} = {r_full, r_full};
                {rs1_used_o, rd_used_o} = 2'b11;
                legal_o = !instr_i[12] && (r_full != 5'd0) && (r2_full != 5'd0);
            end
            5'b10_010: begin
                itype_o = LOAD;
                {rs1_d, rd_d} = {5'd2, r_full};
                {rs1_used_o, rd_used_o, legal_o} = {2'b11, r_full != 5'd0};
            end
            5'b10_100: begin
                if (instr_i[12] && (instr_i[11:2] == 10'd0)) begin
                    itype_o = CSR;
                    legal_o = 1'b1;
                end else if (r2_full != 5'd0) begin
                    // add when bit 12 is set, mv otherwise.
                    {rs1_d, rs2_d, rd_d} = {r_full, r2_full, r_full};
                    {rs1_used_o, rs2_used_o, rd_used_o, legal_o} = {instr_i[12], 3'b111};
                end else begin
                    itype_o = JALR;
                    {rs1_d, rd_d} = {r_full, 4'd0, instr_i[12]};
                    {rs1_used_o, rd_used_o, legal_o} = {2'b11, r_full != 5'd0};
                end
            end
            5'b10_110: begin
                itype_o = STORE;
                {rs1_d, rs2_d} = {5'd2, r2_full};
                {rs1_used_o, rs2_used_o, legal_o} = 3'b111;
            end
            default: legal_o = 1'b0;
        endcase
        if (!legal_o) begin
            itype_o    = BASE;
            rs1_used_o = 1'b0;
            rs2_used_o = 1'b0;
            rd_used_o  = 1'b0;
        end
    end

    assign rs1_o = rs1_used_o ? rs1_d : 5'd0;
    assign rs2_o = rs2_used_o ? rs2_d : 5'd0;
    assign rd_o  = rd_used_o  ? rd_d  : 5'd0;

endmodule

// File: hw/rv32_field_decode.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Combinational decoder for full-length RV32 instructions.
// Returns the instruction type, the rs1/rs2/rd numbers with
// their used flags, and a legal flag for RV32I, M and Zicsr.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module rv32_field_decode import rvtrace_pkg::*; (
    input  xlen_t   instr_i,
    output itype_e  itype_o,
    output regidx_t rs1_o,
    output regidx_t rs2_o,
    output regidx_t rd_o,
    output logic    rs1_used_o,
    output logic    rs2_used_o,
    output logic    rd_used_o,
    output logic    legal_o
);

    logic [4:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = instr_i[6:2];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    always_comb begin
        itype_o    = BASE;
        rs1_used_o = 1'b0;
        rs2_used_o = 1'b0;
        rd_used_o  = 1'b0;
        legal_o    = 1'b0;
        case (opcode)
            OPC_LUI, OPC_AUIPC: begin
                rd_used_o = 1'b1;
                legal_o   = 1'b1;
            end
            OPC_JAL: begin
                itype_o   = JAL;
                rd_used_o = 1'b1;
                legal_o   = 1'b1;
            end
            OPC_JALR: begin
                itype_o    = JALR;
                rs1_used_o = 1'b1;
                rd_used_o  = 1'b1;
                legal_o    = (funct3 == 3'd0);
            end
            OPC_BRANCH: begin
                itype_o    = BRANCH;
                rs1_used_o = 1'b1;
                rs2_used_o = 1'b1;
                legal_o    = (funct3[2:1] != 2'b01);
            end
            OPC_LOAD: begin
                itype_o    = LOAD;
                rs1_used_o = 1'b1;
                rd_used_o  = 1'b1;
                legal_o    = funct3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
            end
            OPC_STORE: begin
                itype_o    = STORE;
                rs1_used_o = 1'b1;
                rs2_used_o = 1'b1;
                legal_o    = (funct3 < 3'd3);
            end
            OPC_OPIMM: begin
                rs1_used_o = 1'b1;
                rd_used_o  = 1'b1;
                // slli takes funct7 0 only, srli and srai take 0 or 32.
                if (funct3 == 3'd1) begin
                    legal_o = (funct7 == 7'd0);
                end else if (funct3 == 3'd5) begin
                    legal_o = (funct7 == 7'd0) || (funct7 == 7'd32);
                end else begin
                    legal_o = 1'b1;
                end
            end
            OPC_OP: begin
                rs1_used_o = 1'b1;
                rs2_used_o = 1'b1;
                rd_used_o  = 1'b1;
                case (funct7)
                    7'd1: begin
                        itype_o = MEXT;
                        legal_o = 1'b1;
                    end
                    7'd0:    legal_o = 1'b1;
                    7'd32:   legal_o = (funct3 == 3'd0) || (funct3 == 3'd5);
                    default: legal_o = 1'b0;
                endcase
            end
            OPC_FENCE: begin
                itype_o = CSR;
                legal_o = (funct3[2:1] == 2'b00);
            end
            OPC_SYSTEM: begin
                itype_o = CSR;
                case (funct3)
                    3'd0: begin
                        // ecall, ebreak and mret.
                        legal_o = (instr_i[19:15] == 5'd0) && (instr_i[11:7] == 5'd0)
                                  && (instr_i[31:20] inside {12'h000, 12'h001, 12'h302});
                    end
                    3'd1, 3'd2, 3'd3: begin
                        rs1_used_o = 1'b1;
                        rd_used_o  = 1'b1;
                        legal_o    = 1'b1;
                    end
                    3'd5, 3'd6, 3'd7: begin
                        rd_used_o = 1'b1;
                        legal_o   = 1'b1;
                    end
                    default: legal_o = 1'b0;
                endcase
            end
            default: legal_o = 1'b0;
        endcase
        if (!legal_o) begin
            itype_o    = BASE;
            rs1_used_o = 1'b0;
            rs2_used_o = 1'b0;
            rd_used_o  = 1'b0;
        end
    end

    assign rs1_o = rs1_used_o ? instr_i[19:15] : 5'd0;
    assign rs2_o = rs2_used_o ? instr_i[24:20] : 5'd0;
    assign rd_o  = rd_used_o  ? instr_i[11:7]  : 5'd0;

endmodule

// File: hw/rvtrace_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared types and constants for the instruction classifier.
// Holds the field widths, the instruction-type enum, the RV32
// major opcodes, the Wishbone register map and the bit layout
// of the result word. Import it wildcard-style in module headers.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package rvtrace_pkg;

    typedef logic [31:0] xlen_t;
    typedef logic [4:0]  regidx_t;
    typedef logic [3:0]  wb_adr_t;
    typedef logic [15:0] ret_cnt_t;

    typedef enum logic [2:0] {BASE, MEXT, LOAD, STORE, BRANCH, JAL, JALR, CSR} itype_e;

    localparam int NUM_ITYPES = 8;

    // register map, word addresses.
    localparam wb_adr_t ADR_INSTR    = 4'd0;
    localparam wb_adr_t ADR_CLEAR    = 4'd1;
    localparam wb_adr_t ADR_TOTAL    = 4'd2;
    localparam wb_adr_t ADR_CNT_BASE = 4'd8;

    // major opcodes, instruction bits 6 to 2.
    localparam logic [4:0] OPC_LUI    = 5'b01101;
    localparam logic [4:0] OPC_AUIPC  = 5'b00101;
    localparam logic [4:0] OPC_JAL    = 5'b11011;
    localparam logic [4:0] OPC_JALR   = 5'b11001;
    localparam logic [4:0] OPC_BRANCH = 5'b11000;
    localparam logic [4:0] OPC_LOAD   = 5'b00000;
    localparam logic [4:0] OPC_STORE  = 5'b01000;
    localparam logic [4:0] OPC_OPIMM  = 5'b00100;
    localparam logic [4:0] OPC_OP     = 5'b01100;
    localparam logic [4:0] OPC_FENCE  = 5'b00011;
    localparam logic [4:0] OPC_SYSTEM = 5'b11100;

    // layout of the result word read back from ADR_INSTR.
    localparam int RES_RS1_LSB    = 0;
    localparam int RES_RS2_LSB    = 5;
    localparam int RES_RD_LSB     = 10;
    localparam int RES_RS1_USED   = 15;
    localparam int RES_RS2_USED   = 16;
    localparam int RES_RD_USED    = 17;
    localparam int RES_ITYPE_LSB  = 18;
    localparam int RES_COMPRESSED = 21;
    localparam int RES_LEGAL      = 22;

endpackage
